// ==== core_pkg.sv ====
package core_pkg;

    typedef logic [31:0] word_t;      // Data word and byte address
    typedef logic [31:0] inst_t;      // Raw instruction
    typedef logic [4:0]  reg_addr_t;  // Architectural register index

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR
    } alu_op_t;

    // Source of an execute operand
    typedef enum logic [1:0] {
        FWD_REG,  // Value read in decode
        FWD_MM,   // Result sitting in the execute/memory register
        FWD_WB    // Result sitting in the memory/writeback register
    } fwd_sel_t;

    typedef struct packed {
        logic  valid;
        word_t pc;
        inst_t inst;
    } id_t;

    typedef struct packed {
        logic      valid;
        word_t     pc;         // For the branch target
        alu_op_t   alu_op;
        reg_addr_t rs1;        // Kept for forwarding compares
        reg_addr_t rs2;
        word_t     rs1_data;
        word_t     rs2_data;
        word_t     imm;        // I, S or B form, sign extended
        logic      use_imm;    // Second ALU operand is imm
        reg_addr_t rd;
        logic      rd_en;
        logic      mem_re;
        logic      mem_we;
        logic      is_branch;
        logic      branch_ne;  // BNE rather than BEQ
    } ex_t;

    typedef struct packed {
        logic      valid;
        word_t     result;     // ALU output, also the data address
        word_t     store_data;
        reg_addr_t rd;
        logic      rd_en;
        logic      mem_re;
        logic      mem_we;
    } mm_t;

    typedef struct packed {
        logic      valid;
        reg_addr_t rd;
        logic      rd_en;
        word_t     data;       // Load data or ALU result
    } wb_t;

    localparam logic [6:0] OP_REG    = 7'b0110011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;

endpackage

// ==== fetch.sv ====
module fetch
    import core_pkg::*;
#(
    parameter word_t RESET_PC = '0
) (
    input  logic  clk,
    input  logic  arst_n,
    input  logic  stall,
    input  logic  branch,
    input  word_t target,
    output word_t code_addr,
    input  inst_t code_data,
    output id_t   id
);

    word_t pc;

    assign code_addr = pc;  // Code port sees the PC directly

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc <= RESET_PC;
        end else if (branch) begin
            pc <= target;  // Redirect wins over everything
        end else if (!stall) begin
            pc <= pc + 32'd4;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            id <= '0;
        end else if (branch) begin
            id.valid <= 1'b0;  // Drop the wrong-path fetch
        end else if (!stall) begin
            id <= '{valid: 1'b1, pc: pc, inst: code_data};
        end
        // Stall keeps the same instruction in decode
    end

endmodule

// ==== regfile.sv ====
module regfile
    import core_pkg::*;
(
    input  logic      clk,
    input  logic      arst_n,
    input  reg_addr_t rs1_addr,
    input  reg_addr_t rs2_addr,
    output word_t     rs1_data,
    output word_t     rs2_data,
    input  wb_t       wb
);

    word_t regs [32];
    logic  we;

    assign we = wb.valid && wb.rd_en;

    always_ff @(posedge clk) begin
        if (arst_n && we) begin
            regs[wb.rd] <= wb.data;  // No writes while reset is held
        end
    end

    // Shared by both read ports
    function automatic word_t read_port(reg_addr_t addr);
        if (addr == '0) return '0;               // x0 reads as zero
        if (we && wb.rd == addr) return wb.data;  // Write-first bypass
        return regs[addr];
    endfunction

    always_comb begin
        rs1_data = read_port(rs1_addr);
        rs2_data = read_port(rs2_addr);
    end

endmodule

// ==== decode.sv ====
module decode
    import core_pkg::*;
(
    input  logic      clk,
    input  logic      arst_n,
    input  logic      stall,
    input  logic      branch,
    input  id_t       id,
    output reg_addr_t rs1_addr,
    output reg_addr_t rs2_addr,
    input  word_t     rs1_data,
    input  word_t     rs2_data,
    output ex_t       ex
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    reg_addr_t  rd;
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_b;
    logic       supported;  // Encoding is in the implemented subset
    ex_t        nxt;

    assign opcode   = id.inst[6:0];
    assign rd       = id.inst[11:7];
    assign funct3   = id.inst[14:12];
    assign rs1_addr = id.inst[19:15];
    assign rs2_addr = id.inst[24:20];
    assign funct7   = id.inst[31:25];

    assign imm_i = {{20{id.inst[31]}}, id.inst[31:20]};
    assign imm_s = {{20{id.inst[31]}}, id.inst[31:25], id.inst[11:7]};
    assign imm_b = {{19{id.inst[31]}}, id.inst[31], id.inst[7],
                    id.inst[30:25], id.inst[11:8], 1'b0};  // Bit 0 always clear

    always_comb begin
        supported = 1'b0;
        nxt       = '0;
        nxt.pc       = id.pc;
        nxt.rs1      = rs1_addr;
        nxt.rs2      = rs2_addr;
        nxt.rs1_data = rs1_data;
        nxt.rs2_data = rs2_data;
        nxt.rd       = rd;
        nxt.imm      = imm_i;    // Most common form
        nxt.alu_op   = ALU_ADD;  // Also the address adder
        case (opcode)
            OP_REG: begin
                nxt.rd_en = 1'b1;
                case (funct3)
                    3'b000: begin
                        supported  = (funct7 == 7'h00) || (funct7 == 7'h20);
                        nxt.alu_op = funct7[5] ? ALU_SUB : ALU_ADD;
                    end
                    3'b100: begin
                        supported  = (funct7 == 7'h00);
                        nxt.alu_op = ALU_XOR;
                    end
                    3'b110: begin
                        supported  = (funct7 == 7'h00);
                        nxt.alu_op = ALU_OR;
                    end
                    3'b111: begin
                        supported  = (funct7 == 7'h00);
                        nxt.alu_op = ALU_AND;
                    end
                    default: supported = 1'b0;
                endcase
            end
            OP_IMM: begin
                supported   = (funct3 == 3'b000);  // ADDI only
                nxt.use_imm = 1'b1;
                nxt.rd_en   = 1'b1;
            end
            OP_LOAD: begin
                supported   = (funct3 == 3'b010);  // LW only
                nxt.use_imm = 1'b1;
                nxt.rd_en   = 1'b1;
                nxt.mem_re  = 1'b1;
            end
            OP_STORE: begin
                supported   = (funct3 == 3'b010);  // SW only
                nxt.use_imm = 1'b1;
                nxt.imm     = imm_s;
                nxt.mem_we  = 1'b1;
            end
            OP_BRANCH: begin
                supported     = (funct3 == 3'b000) || (funct3 == 3'b001);
                nxt.imm       = imm_b;
                nxt.is_branch = 1'b1;
                nxt.branch_ne = funct3[0];
            end
            default: supported = 1'b0;  // Everything else is a bubble
        endcase
        nxt.valid = id.valid && supported;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ex <= '0;
        end else if (stall || branch) begin
            ex.valid <= 1'b0;  // Bubble for load-use or flush
        end else begin
            ex <= nxt;
        end
    end

endmodule

// ==== execute.sv ====
module execute
    import core_pkg::*;
(
    input  logic     clk,
    input  logic     arst_n,
    input  ex_t      ex,
    input  fwd_sel_t fwd_a,
    input  fwd_sel_t fwd_b,
    input  wb_t      wb,
    output logic     branch,
    output word_t    target,
    output mm_t      mm
);

    word_t op_a;
    word_t rs2_fwd;  // Forwarded rs2, compare operand and store data
    word_t op_b;
    word_t result;

    always_comb begin
        case (fwd_a)
            FWD_MM:  op_a = mm.result;
            FWD_WB:  op_a = wb.data;
            default: op_a = ex.rs1_data;
        endcase
        case (fwd_b)
            FWD_MM:  rs2_fwd = mm.result;
            FWD_WB:  rs2_fwd = wb.data;
            default: rs2_fwd = ex.rs2_data;
        endcase
    end

    assign op_b = ex.use_imm ? ex.imm : rs2_fwd;

    always_comb begin
        case (ex.alu_op)
            ALU_SUB: result = op_a - op_b;
            ALU_AND: result = op_a & op_b;
            ALU_OR:  result = op_a | op_b;
            ALU_XOR: result = op_a ^ op_b;
            default: result = op_a + op_b;
        endcase
    end

    // Taken when equality differs from the NE flag
    assign branch = ex.valid && ex.is_branch && ((op_a == rs2_fwd) != ex.branch_ne);
    assign target = ex.pc + ex.imm;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mm <= '0;
        end else begin
            mm.valid      <= ex.valid;
            mm.result     <= result;
            mm.store_data <= rs2_fwd;
            mm.rd         <= ex.rd;
            mm.rd_en      <= ex.rd_en;
            mm.mem_re     <= ex.mem_re;
            mm.mem_we     <= ex.mem_we;
        end
    end

endmodule

// ==== memory.sv ====
module memory
    import core_pkg::*;
(
    input  logic  clk,
    input  logic  arst_n,
    input  mm_t   mm,
    output word_t data_addr,
    output word_t data_wdata,
    output logic  data_we,
    output logic  data_re,
    input  word_t data_rdata,
    output wb_t   wb
);

    word_t rd_data;

    assign data_addr  = mm.result;   // Base plus offset from the ALU
    assign data_wdata = mm.store_data;
    assign data_we    = mm.valid && mm.mem_we;  // One cycle per store
    assign data_re    = mm.valid && mm.mem_re;  // Level while the load sits here

    // Load data arrives in the same cycle as the address
    assign rd_data = mm.mem_re ? data_rdata : mm.result;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wb <= '0;
        end else begin
            wb.valid <= mm.valid;
            wb.rd    <= mm.rd;
            wb.rd_en <= mm.rd_en;
            wb.data  <= rd_data;
        end
    end

endmodule

// ==== hazard_unit.sv ====
module hazard_unit
    import core_pkg::*;
(
    input  id_t      id,
    input  ex_t      ex,
    input  mm_t      mm,
    input  wb_t      wb,
    output logic     stall,
    output fwd_sel_t fwd_a,
    output fwd_sel_t fwd_b
);

    logic [6:0] id_op;
    reg_addr_t  id_rs1;
    reg_addr_t  id_rs2;
    logic       uses_rs1;
    logic       uses_rs2;
    logic       load_in_ex;

    assign id_op  = id.inst[6:0];
    assign id_rs1 = id.inst[19:15];
    assign id_rs2 = id.inst[24:20];

    // Real source fields only so imm bits cause no false stalls
    assign uses_rs1 = id_op inside {OP_REG, OP_IMM, OP_LOAD, OP_STORE, OP_BRANCH};
    assign uses_rs2 = id_op inside {OP_REG, OP_STORE, OP_BRANCH};

    assign load_in_ex = ex.valid && ex.mem_re && ex.rd_en && (ex.rd != '0);

    assign stall = id.valid && load_in_ex &&
                   ((uses_rs1 && id_rs1 == ex.rd) || (uses_rs2 && id_rs2 == ex.rd));

    // Youngest producer wins
    function automatic fwd_sel_t pick(reg_addr_t rs, mm_t m, wb_t w);
        if (rs == '0) return FWD_REG;
        if (m.valid && m.rd_en && !m.mem_re && m.rd == rs) return FWD_MM;
        if (w.valid && w.rd_en && w.rd == rs) return FWD_WB;
        return FWD_REG;
    endfunction

    assign fwd_a = pick(ex.rs1, mm, wb);
    assign fwd_b = pick(ex.rs2, mm, wb);

endmodule

// ==== cpu.sv ====
module cpu
    import core_pkg::*;
#(
    parameter word_t RESET_PC = '0
) (
    input  logic  clk,
    input  logic  arst_n,
    output word_t code_addr,
    input  inst_t code_data,
    output word_t data_addr,
    output word_t data_wdata,
    output logic  data_we,
    output logic  data_re,
    input  word_t data_rdata
);

    id_t       id;      // Fetch to decode
    ex_t       ex;      // Decode to execute
    mm_t       mm;      // Execute to memory
    wb_t       wb;      // Memory to writeback
    logic      stall;   // Load-use hold
    logic      branch;  // Taken branch flush
    word_t     target;
    fwd_sel_t  fwd_a;
    fwd_sel_t  fwd_b;
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    word_t     rs1_data;
    word_t     rs2_data;

    hazard_unit i_hazard_unit (
        .id, .ex, .mm, .wb,
        .stall,
        .fwd_a,
        .fwd_b
    );

    fetch #(
        .RESET_PC(RESET_PC)
    ) i_fetch (
        .clk, .arst_n,
        .stall, .branch, .target,
        .code_addr, .code_data,
        .id
    );

    regfile i_regfile (
        .clk, .arst_n,
        .rs1_addr, .rs2_addr,
        .rs1_data, .rs2_data,
        .wb  // Write port driven by the writeback register
    );

    decode i_decode (
        .clk, .arst_n,
        .stall, .branch,
        .id,
        .rs1_addr, .rs2_addr,
        .rs1_data, .rs2_data,
        .ex
    );

    execute i_execute (
        .clk, .arst_n,
        .ex, .fwd_a, .fwd_b, .wb,
        .branch, .target,
        .mm
    );

    memory i_memory (
        .clk, .arst_n,
        .mm,
        .data_addr, .data_wdata, .data_we, .data_re, .data_rdata,
        .wb
    );

endmodule

// ==== tb_clock.sv ====
module tb_clock #(
    parameter int PERIOD       = 8,
    parameter int RESET_CYCLES = 5
) (
    output logic clk,
    output logic arst_n
);

    initial begin
        clk    = 1'b0;
        arst_n = 1'b0;                        // Reset held from time zero
        repeat (RESET_CYCLES) @(posedge clk);
        arst_n <= 1'b1;                       // Release on a rising edge
    end

    always #(PERIOD / 2) clk = ~clk;

endmodule

// ==== cpu_sva.sv ====
module cpu_sva
    import core_pkg::*;
(
    input logic  clk,
    input logic  arst_n,
    input word_t code_addr,
    input logic  data_we,
    input logic  data_re,
    input logic  stall,   // Internal load-use hold
    input logic  branch   // Internal taken-branch flush
);

    // Only one instruction sits in the memory stage
    a_we_re_exclusive: assert property (@(posedge clk) disable iff (!arst_n)
        !(data_we && data_re))
        else $error("data_we and data_re high in the same cycle");

    a_quiet_in_reset: assert property (@(posedge clk)
        !arst_n |-> (!data_we && !data_re))  // No strobes while reset is held
        else $error("data strobe high during reset");

    a_code_aligned: assert property (@(posedge clk) disable iff (!arst_n)
        code_addr[1:0] == 2'b00)
        else $error("code_addr not word aligned");

    // Load and branch both live in execute
    a_no_stall_and_branch: assert property (@(posedge clk) disable iff (!arst_n)
        !(stall && branch))
        else $error("stall and branch in the same cycle");

endmodule

// ==== cpu_tb.sv ====
module cpu_tb
    import core_pkg::*;
();

    typedef enum logic [2:0] {
        ROW_ADD, ROW_SUB, ROW_AND, ROW_OR, ROW_XOR, ROW_ADDI, ROW_BEQ, ROW_BNE
    } row_op_t;

    typedef struct packed {
        row_op_t     op;
        logic [11:0] imm;   // ADDI only
        word_t       addr;  // Where the result is stored
        logic        same;  // b forced equal to a
    } row_t;

    typedef struct packed {
        word_t addr;
        word_t data;
    } store_t;

    localparam int    CLK_PERIOD      = 8;
    localparam word_t RESET_PC        = 32'h0000_0040;  // Not zero on purpose
    localparam int    ROM_WORDS       = 256;
    localparam int    RAM_WORDS       = 512;
    localparam int    NUM_ROWS        = 12;
    localparam int    WATCHDOG_CYCLES = NUM_ROWS * 40 + 100;

    localparam row_t ROWS [NUM_ROWS] = '{
        '{ROW_ADD,  12'h000, 32'h0000_0400, 1'b0},
        '{ROW_SUB,  12'h000, 32'h0000_0404, 1'b0},
        '{ROW_AND,  12'h000, 32'h0000_0408, 1'b0},
        '{ROW_OR,   12'h000, 32'h0000_040c, 1'b0},
        '{ROW_XOR,  12'h000, 32'h0000_0410, 1'b0},
        '{ROW_ADDI, 12'h7ff, 32'h0000_0414, 1'b0},  // Largest positive imm
        '{ROW_ADDI, 12'h800, 32'h0000_0418, 1'b0},  // Most negative imm
        '{ROW_BEQ,  12'h000, 32'h0000_041c, 1'b1},  // Taken
        '{ROW_BEQ,  12'h000, 32'h0000_0420, 1'b0},
        '{ROW_BNE,  12'h000, 32'h0000_0424, 1'b1},  // Not taken
        '{ROW_BNE,  12'h000, 32'h0000_0428, 1'b0},
        '{ROW_SUB,  12'h000, 32'h0000_042c, 1'b1}   // Result zero
    };

    logic   clk;
    logic   arst_n;
    word_t  code_addr;
    inst_t  code_data;
    word_t  data_addr;
    word_t  data_wdata;
    logic   data_we;
    logic   data_re;
    word_t  data_rdata;

    inst_t  rom [ROM_WORDS];
    word_t  ram [RAM_WORDS];
    store_t expected_q [$];     // Stores in program order
    word_t  load_q [$];         // Load addresses in program order
    word_t  lfsr = 32'h65f1;
    int     rom_ptr;
    int     stores_seen = 0;

    tb_clock #(.PERIOD(CLK_PERIOD), .RESET_CYCLES(5)) i_clock (.clk, .arst_n);

    cpu #(
        .RESET_PC(RESET_PC)
    ) i_dut (
        .clk, .arst_n,
        .code_addr, .code_data,
        .data_addr, .data_wdata, .data_we, .data_re, .data_rdata
    );

    bind cpu cpu_sva i_cpu_sva (
        .clk, .arst_n, .code_addr, .data_we, .data_re, .stall, .branch
    );

    // Past the program the ROM reads as bubbles
    assign code_data  = (code_addr < 32'(ROM_WORDS * 4)) ? rom[code_addr[9:2]] : '0;
    assign data_rdata = ram[data_addr[10:2]];  // Same-cycle read

    always @(posedge clk) begin
        if (data_we) begin
            ram[data_addr[10:2]] <= data_wdata;
        end
    end

    function automatic word_t lfsr_step(word_t s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // Taps 32 22 2 1
    endfunction

    function automatic word_t random_word();
        word_t w;
        w = '0;
        for (int k = 0; k < 32; k++) begin
            lfsr = lfsr_step(lfsr);
            w    = {w[30:0], lfsr[0]};  // One step per bit
        end
        return w;
    endfunction

    // Reference results from the RV32I definitions
    function automatic word_t expected_result(row_t r, word_t a, word_t b);
        case (r.op)
            ROW_ADD:  return a + b;
            ROW_SUB:  return a - b;
            ROW_AND:  return a & b;
            ROW_OR:   return a | b;
            ROW_XOR:  return a ^ b;
            ROW_ADDI: return a + {{20{r.imm[11]}}, r.imm};
            ROW_BEQ:  return (a == b) ? 32'd1 : 32'd2;
            default:  return (a != b) ? 32'd1 : 32'd2;
        endcase
    endfunction

    function automatic inst_t enc_i(logic [11:0] imm, reg_addr_t rs1, logic [2:0] f3,
                                    reg_addr_t rd, logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic inst_t enc_s(logic [11:0] imm, reg_addr_t rs2, reg_addr_t rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OP_STORE};
    endfunction

    function automatic inst_t enc_r(logic [6:0] f7, logic [2:0] f3);
        return {f7, 5'd2, 5'd1, f3, 5'd3, OP_REG};  // x3 = x1 op x2
    endfunction

    function automatic inst_t enc_b(logic [12:0] off, logic [2:0] f3);
        return {off[12], off[10:5], 5'd2, 5'd1, f3, off[4:1], off[11], OP_BRANCH};
    endfunction

    task automatic emit_inst(inst_t w);
        rom[rom_ptr] = w;
        rom_ptr++;
    endtask

    task automatic build_row(row_t r, word_t a_addr);
        word_t b_addr;
        b_addr = a_addr + 32'd4;
        emit_inst(enc_i(a_addr[11:0], 5'd0, 3'b010, 5'd1, OP_LOAD));  // lw x1
        emit_inst(enc_i(b_addr[11:0], 5'd0, 3'b010, 5'd2, OP_LOAD));  // lw x2
        case (r.op)
            ROW_ADD:  emit_inst(enc_r(7'h00, 3'b000));  // Uses x2 at once
            ROW_SUB:  emit_inst(enc_r(7'h20, 3'b000));
            ROW_AND:  emit_inst(enc_r(7'h00, 3'b111));
            ROW_OR:   emit_inst(enc_r(7'h00, 3'b110));
            ROW_XOR:  emit_inst(enc_r(7'h00, 3'b100));
            ROW_ADDI: emit_inst(enc_i(r.imm, 5'd1, 3'b000, 5'd3, OP_IMM));
            default: begin
                emit_inst(enc_i(12'd1, 5'd0, 3'b000, 5'd3, OP_IMM));  // x3 = 1
                emit_inst(enc_b(13'd8, (r.op == ROW_BNE) ? 3'b001 : 3'b000));
                emit_inst(enc_i(12'd2, 5'd0, 3'b000, 5'd3, OP_IMM));  // Skipped if taken
            end
        endcase
        emit_inst(enc_s(r.addr[11:0], 5'd3, 5'd0));  // sw x3
    endtask

    task automatic stop_with_failure();
        $display("** FAIL **");
        $fatal(1, "Run stopped at the first failure");
    endtask

    task automatic check_word(word_t got, word_t want, string what);
        if (got !== want) begin
            $display("** Error at %0t: %s is %h, expected %h", $time, what, got, want);
            stop_with_failure();
        end
    endtask

    task automatic check_addr(word_t got, word_t want, string what);
        if (got !== want) begin
            $display("** Error at %0t: %s is %h, expected %h", $time, what, got, want);
            stop_with_failure();
        end
    endtask

    task automatic check_bit(logic got, logic want, string what);
        if (got !== want) begin
            $display("** Error at %0t: %s is %b, expected %b", $time, what, got, want);
            stop_with_failure();
        end
    endtask

    always @(negedge clk) begin : store_monitor
        store_t want;
        word_t  want_load;
        if (!arst_n) begin
            check_bit(data_we, 1'b0, "data_we in reset");
            check_bit(data_re, 1'b0, "data_re in reset");
        end else if (data_we) begin
            if (expected_q.size() == 0) begin
                $display("Unexpected store to address %h after all rows", data_addr);
                stop_with_failure();
            end else begin
                want = expected_q.pop_front();  // Strict program order
                check_addr(data_addr, want.addr, "store address");
                check_word(data_wdata, want.data, "store data");
                stores_seen++;
            end
        end else if (data_re) begin
            if (load_q.size() == 0) begin
                $display("Unexpected load from address %h after all rows", data_addr);
                stop_with_failure();
            end else begin
                want_load = load_q.pop_front();  // One cycle per load
                check_addr(data_addr, want_load, "load address");
            end
        end
    end

    initial begin : watchdog
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout after %0d cycles with %0d of %0d stores seen",
                 WATCHDOG_CYCLES, stores_seen, NUM_ROWS);
        stop_with_failure();
    end

    initial begin : main
        word_t a;
        word_t b;
        word_t a_addr;
        rom_ptr = int'(RESET_PC >> 2);
        for (int i = 0; i < ROM_WORDS; i++) begin
            rom[i] = '0;  // Zero words decode as bubbles
        end
        for (int i = 0; i < RAM_WORDS; i++) begin
            ram[i] <= (word_t'(i) * 32'h9e37_79b9) ^ 32'h5a5a_0000;
        end
        for (int i = 0; i < NUM_ROWS; i++) begin
            a      = random_word();
            b      = ROWS[i].same ? a : random_word();
            a_addr = word_t'(i * 8);  // Operand pair per row
            ram[a_addr[10:2]]         <= a;
            ram[a_addr[10:2] + 9'd1]  <= b;
            load_q.push_back(a_addr);
            load_q.push_back(a_addr + 32'd4);
            expected_q.push_back('{addr: ROWS[i].addr, data: expected_result(ROWS[i], a, b)});
            build_row(ROWS[i], a_addr);
        end
        @(posedge arst_n);
        @(negedge clk);
        check_addr(code_addr, RESET_PC, "code address after reset");
        wait (stores_seen == NUM_ROWS);
        repeat (20) @(negedge clk);  // Window for a stray extra store
        if (load_q.size() == 0) begin
            $display("** PASS **");
            $finish;
        end else begin
            $display("Run ended with %0d loads never seen on the data port", load_q.size());
            stop_with_failure();
        end
    end

endmodule

// ==== filelist.f ====
core_pkg.sv
fetch.sv
regfile.sv
decode.sv
execute.sv
memory.sv
hazard_unit.sv
cpu.sv
tb_clock.sv
cpu_sva.sv
cpu_tb.sv

// ==== Makefile ====
SRCS := $(shell cat filelist.f)

obj_dir/Vcpu_tb: filelist.f $(SRCS)
	verilator --binary --timing --assert -f filelist.f --top-module cpu_tb -Mdir obj_dir

run: obj_dir/Vcpu_tb
	./obj_dir/Vcpu_tb > sim.log 2>&1; cat sim.log
	grep -q '^\*\* PASS \*\*$$' sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean
